// ==== common/sdram_pkg.sv ====
package sdram_pkg;

    // Device size in bytes, which selects the bank, row and column split.
    localparam int mem_size = 32 * 1024 * 1024;
    localparam int clk_freq = 25_000_000;
    localparam int ns_per_clk = 1_000_000_000 / clk_freq;

    // Power-up wait of 100 us.
    localparam int t_reset = 100_000 / ns_per_clk;

    // Device timings in clock cycles.
    localparam int t_rc = 8;
    localparam int t_rp = 2;
    localparam int t_mrd = 2;
    localparam int t_rcd = 2;
    localparam int cas_latency = 2;

    // 8192 refreshes every 64 ms.
    localparam int t_ref = ((64 * 1_000_000) / ns_per_clk) / 8192;

    // Longest idle-to-idle access: request sample, activate, the longer column phase,
    // and the completion cycle in idle. A refresh must be started this early.
    localparam int max_cmd_period =
        t_rcd + ((cas_latency > t_rp) ? cas_latency : t_rp) + 3;

    localparam int timec_width = $clog2(t_reset + 1);
    localparam int refresh_width = $clog2(t_ref);

    localparam int bank_width = 2;
    localparam int row_width = 13;
    localparam int data_width = 16;

    // Burst length 2, sequential, CAS latency 2, burst writes.
    localparam logic [row_width-1:0] mode_word = 13'b000_0_00_010_0_001;

    // Encoded as {cs_n, ras_n, cas_n, we_n}.
    typedef enum logic [3:0] {
        cmd_nop        = 4'b0111,
        cmd_burst_stop = 4'b0110,
        cmd_read       = 4'b0101,
        cmd_write      = 4'b0100,
        cmd_activate   = 4'b0011,
        cmd_precharge  = 4'b0010,
        cmd_refresh    = 4'b0001,
        cmd_mode_set   = 4'b0000
    } sdram_cmd_e;

    typedef enum logic [3:0] {
        st_reset_wait = 4'b0000,
        st_reset_pch  = 4'b0001,
        st_reset_ref1 = 4'b0011,
        st_reset_ref2 = 4'b0010,
        st_mode_set   = 4'b0110,
        st_idle       = 4'b0111,
        st_activate   = 4'b0101,
        st_read       = 4'b1101,
        st_write      = 4'b1001,
        st_autoref    = 4'b1010
    } ctrl_state_e;

endpackage

// ==== filelist.f ====
common/sdram_pkg.sv
sdram_controller/timing_counter.sv
sdram_controller/sdram_controller.sv
hw/sdram_top.sv
verification/sdram_chk.sv
verification/sdram_model.sv
verification/tb_sdram.sv

// ==== hw/sdram_top.sv ====
module sdram_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cs,
    input  logic [25:1]                        h_addr,
    input  logic [sdram_pkg::data_width-1:0]   h_wdata,
    input  logic                               h_wr_en,
    input  logic [1:0]                         h_bytesel,
    output logic [sdram_pkg::data_width-1:0]   h_rdata,
    output logic                               h_compl,
    output logic                               h_config_done,
    output logic                               s_ras_n,
    output logic                               s_cas_n,
    output logic                               s_wr_en,
    output logic [1:0]                         s_bytesel,
    output logic [sdram_pkg::row_width-1:0]    s_addr,
    output logic                               s_cs_n,
    output logic                               s_clken,
    output logic [sdram_pkg::bank_width-1:0]   s_banksel,
    inout  wire  [sdram_pkg::data_width-1:0]   s_data
);

    // Host pins on one side, device pins on the other.
    sdram_controller ctrl_i (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .h_addr(h_addr),
        .h_wdata(h_wdata),
        .h_wr_en(h_wr_en),
        .h_bytesel(h_bytesel),
        .h_rdata(h_rdata),
        .h_compl(h_compl),
        .h_config_done(h_config_done),
        .s_ras_n(s_ras_n),
        .s_cas_n(s_cas_n),
        .s_wr_en(s_wr_en),
        .s_bytesel(s_bytesel),
        .s_addr(s_addr),
        .s_cs_n(s_cs_n),
        .s_clken(s_clken),
        .s_banksel(s_banksel),
        .s_data(s_data)
    );

endmodule

// ==== sdram_controller/sdram_controller.sv ====
module sdram_controller (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               cs,
    input  logic [25:1]                        h_addr,
    input  logic [sdram_pkg::data_width-1:0]   h_wdata,
    input  logic                               h_wr_en,
    input  logic [1:0]                         h_bytesel,
    output logic [sdram_pkg::data_width-1:0]   h_rdata,
    output logic                               h_compl,
    output logic                               h_config_done,
    output logic                               s_ras_n,
    output logic                               s_cas_n,
    output logic                               s_wr_en,
    output logic [1:0]                         s_bytesel,
    output logic [sdram_pkg::row_width-1:0]    s_addr,
    output logic                               s_cs_n,
    output logic                               s_clken,
    output logic [sdram_pkg::bank_width-1:0]   s_banksel,
    inout  wire  [sdram_pkg::data_width-1:0]   s_data
);

    import sdram_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    sdram_cmd_e cmd;

    logic [timec_width-1:0] timec;
    logic timec_clear;
    logic [refresh_width-1:0] refresh_count;
    logic refresh_clear;
    logic refresh_pending;

    logic [data_width-1:0] out_data;
    logic [1:0] out_mask;
    logic drive_data;

    logic [bank_width-1:0] h_bank;
    logic [row_width-1:0] h_row;
    logic [row_width-1:0] h_col_pchg;

    // Pin outputs.
    assign {s_cs_n, s_ras_n, s_cas_n, s_wr_en} = cmd;
    assign s_clken = 1'b1;

    // The first two write cycles carry the burst of two.
    assign drive_data = (state == st_write) && (timec < timec_width'(2));
    assign s_data = drive_data ? out_data : {data_width{1'bz}};

    // Second beat of the write burst is masked so the neighbouring column is untouched.
    assign s_bytesel = (state == st_write && timec == timec_width'(1)) ? 2'b11 : out_mask;

    // Address split. Bit 10 of the column address requests auto-precharge,
    // and the byte address bit 0 is ignored.
    generate
        if (mem_size == 32 * 1024 * 1024) begin : g_split_32m
            assign h_bank = h_addr[24:23];
            assign h_row = h_addr[22:10];
            assign h_col_pchg = {2'b00, 1'b1, 1'b0, h_addr[9:1]};
        end else begin : g_split_64m
            assign h_bank = h_addr[25:24];
            assign h_row = h_addr[23:11];
            assign h_col_pchg = {2'b00, 1'b1, h_addr[10:1]};
        end
    endgenerate

    // State timer restarts on each state change.
    assign timec_clear = reset || (state != next_state);

    timing_counter #(
        .count_width(timec_width),
        .count_max(t_reset)
    ) state_timer_i (
        .clk(clk),
        .clear(timec_clear),
        .count(timec)
    );

    // Refresh spacing; it saturates early enough to leave room for one access.
    assign refresh_clear = reset || (state == st_autoref && timec == timec_width'(t_rc - 1));
    assign refresh_pending = refresh_count == refresh_width'(t_ref - max_cmd_period);

    timing_counter #(
        .count_width(refresh_width),
        .count_max(t_ref - max_cmd_period)
    ) refresh_timer_i (
        .clk(clk),
        .clear(refresh_clear),
        .count(refresh_count)
    );

    always_comb begin
        next_state = state;
        case (state)
            st_reset_wait: begin
                if (timec == timec_width'(t_reset - 1)) begin
                    next_state = st_reset_pch;
                end
            end
            st_reset_pch: begin
                if (timec == timec_width'(t_rp - 1)) begin
                    next_state = st_reset_ref1;
                end
            end
            st_reset_ref1: begin
                if (timec == timec_width'(t_rc - 1)) begin
                    next_state = st_reset_ref2;
                end
            end
            st_reset_ref2: begin
                if (timec == timec_width'(t_rc - 1)) begin
                    next_state = st_mode_set;
                end
            end
            st_mode_set: begin
                if (timec == timec_width'(t_mrd - 1)) begin
                    next_state = st_idle;
                end
            end
            st_idle: begin
                // A due refresh wins over a waiting host request.
                if (!h_compl && refresh_pending) begin
                    next_state = st_autoref;
                end else if (!h_compl && cs) begin
                    next_state = st_activate;
                end
            end
            st_activate: begin
                if (timec == timec_width'(t_rcd - 1)) begin
                    next_state = h_wr_en ? st_write : st_read;
                end
            end
            st_read: begin
                if (timec == timec_width'(cas_latency)) begin
                    next_state = st_idle;
                end
            end
            st_write: begin
                if (timec == timec_width'(t_rp)) begin
                    next_state = st_idle;
                end
            end
            st_autoref: begin
                if (timec == timec_width'(t_rc - 1)) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_reset_wait;
        end else begin
            state <= next_state;
        end
    end

    // One command on entry to a state, nop otherwise.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd <= cmd_nop;
            s_addr <= '0;
            s_banksel <= '0;
        end else begin
            cmd <= cmd_nop;
            s_addr <= '0;
            s_banksel <= '0;
            if (state != next_state) begin
                case (next_state)
                    st_reset_pch: begin
                        // A10 high selects all banks.
                        cmd <= cmd_precharge;
                        s_addr <= 13'b0_0100_0000_0000;
                        s_banksel <= 2'b11;
                    end
                    st_reset_ref1, st_reset_ref2, st_autoref: begin
                        cmd <= cmd_refresh;
                    end
                    st_mode_set: begin
                        cmd <= cmd_mode_set;
                        s_addr <= mode_word;
                    end
                    st_activate: begin
                        cmd <= cmd_activate;
                        s_addr <= h_row;
                        s_banksel <= h_bank;
                    end
                    st_read: begin
                        cmd <= cmd_read;
                        s_addr <= h_col_pchg;
                        s_banksel <= h_bank;
                    end
                    st_write: begin
                        cmd <= cmd_write;
                        s_addr <= h_col_pchg;
                        s_banksel <= h_bank;
                    end
                    default: begin
                        cmd <= cmd_nop;
                    end
                endcase
            end
        end
    end

    // Write payload is taken while idle; the host holds it until completion.
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            out_data <= h_wdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_mask <= 2'b00;
        end else if (state == st_idle) begin
            out_mask <= h_wr_en ? ~h_bytesel : 2'b00;
        end
    end

    // First beat of the read burst arrives cas_latency cycles after the command.
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            h_rdata <= '0;
        end else if (state == st_read && timec == timec_width'(cas_latency)) begin
            h_rdata <= s_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_compl <= 1'b0;
        end else begin
            h_compl <= (state == st_read && timec == timec_width'(cas_latency)) ||
                       (state == st_write && timec == timec_width'(t_rp)) ||
                       (state == st_mode_set && timec == timec_width'(t_mrd - 1));
        end
    end

    // Set once on the first idle cycle and held.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_config_done <= 1'b0;
        end else if (state == st_idle) begin
            h_config_done <= 1'b1;
        end
    end

endmodule

// ==== sdram_controller/timing_counter.sv ====
module timing_counter #(
    parameter int count_width = 8,
    parameter int count_max = 255
) (
    input  logic                   clk,
    input  logic                   clear,
    output logic [count_width-1:0] count
);

    localparam logic [count_width-1:0] count_limit = count_width'(count_max);

    // Counts up once per cycle from clear and holds at the limit.
    always_ff @(posedge clk) begin
        if (clear) begin
            count <= '0;
        end else if (count != count_limit) begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== verification/sdram_chk.sv ====
module sdram_chk (
    input  logic                      clk,
    input  logic                      reset,
    input  sdram_pkg::ctrl_state_e    state,
    input  sdram_pkg::sdram_cmd_e     cmd,
    input  logic                      drive_data,
    input  logic                      h_compl
);

    import sdram_pkg::*;

    // Number of failed assertions, visible to the testbench.
    int unsigned fail_count = 0;

    // Completion is a single-cycle strobe.
    compl_single_a: assert property (@(posedge clk) disable iff (reset)
        h_compl |=> !h_compl)
        else begin
            fail_count = fail_count + 1;
            $error("h_compl stayed high for two cycles");
        end

    // The controller drives the data bus only while writing, in the cycle of the
    // write command and the beat after it.
    data_drive_a: assert property (@(posedge clk) disable iff (reset)
        drive_data |-> (state == st_write) &&
            ((cmd == cmd_write) || ($past(cmd) == cmd_write)))
        else begin
            fail_count = fail_count + 1;
            $error("s_data driven outside the write state");
        end

    // Refresh comes from the init sequence or from idle into autoref.
    refresh_origin_a: assert property (@(posedge clk) disable iff (reset)
        (cmd == cmd_refresh) |->
            (state inside {st_reset_ref1, st_reset_ref2}) ||
            (state == st_autoref && $past(state) == st_idle))
        else begin
            fail_count = fail_count + 1;
            $error("refresh command issued from an unexpected state");
        end

endmodule

bind sdram_controller sdram_chk chk_i (
    .clk(clk),
    .reset(reset),
    .state(state),
    .cmd(cmd),
    .drive_data(drive_data),
    .h_compl(h_compl)
);

// ==== verification/sdram_golden.txt ====
// op (1 write, 0 read), byte address, write data, byte select, expected read data
// byte select bit 0 enables the low byte; expected data is unused for writes
1 0000100 1234 3 0000
0 0000100 0000 0 1234
1 0000200 55ab 1 0000
1 0000200 cd77 2 0000
0 0000200 0000 0 cdab
1 0801420 1111 3 0000
1 1002420 2222 3 0000
1 1803c20 3333 3 0000
1 0000c20 4444 3 0000
1 0801820 5555 3 0000
0 0801420 0000 0 1111
0 1002420 0000 0 2222
0 1803c20 0000 0 3333
0 0000c20 0000 0 4444
0 0801820 0000 0 5555
0 0801422 0000 0 0000

// ==== verification/sdram_model.sv ====
module sdram_model (
    input  logic                               clk,
    input  logic                               s_cs_n,
    input  logic                               s_ras_n,
    input  logic                               s_cas_n,
    input  logic                               s_wr_en,
    input  logic [1:0]                         s_bytesel,
    input  logic [sdram_pkg::row_width-1:0]    s_addr,
    input  logic [sdram_pkg::bank_width-1:0]   s_banksel,
    inout  wire  [sdram_pkg::data_width-1:0]   s_data
);

    import sdram_pkg::*;

    // Only the low row bits are stored, which keeps the array small.
    localparam int stored_row_bits = 4;
    localparam int col_bits = 9;
    localparam int index_width = bank_width + stored_row_bits + col_bits;

    sdram_cmd_e cmd;
    logic [data_width-1:0] mem [0:(1 << index_width)-1];
    logic [row_width-1:0] open_row [0:3];
    logic [index_width-1:0] cmd_index;
    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;
    logic [data_width-1:0] dq_out = '0;
    logic drive_en = 1'b0;
    logic rd_second = 1'b0;
    logic wr_second = 1'b0;
    int rd_delay = 0;

    assign cmd = sdram_cmd_e'({s_cs_n, s_ras_n, s_cas_n, s_wr_en});
    assign cmd_index = {s_banksel, open_row[s_banksel][stored_row_bits-1:0],
                        s_addr[col_bits-1:0]};
    assign s_data = drive_en ? dq_out : {data_width{1'bz}};

    initial begin
        for (int i = 0; i < (1 << index_width); i++) begin
            mem[i] = '0;
        end
        for (int b = 0; b < 4; b++) begin
            open_row[b] = '0;
        end
    end

    // DQM high masks the byte.
    task automatic store_word(input logic [index_width-1:0] idx, input logic [1:0] dqm);
        if (!dqm[0]) begin
            mem[idx][7:0] = s_data[7:0];
        end
        if (!dqm[1]) begin
            mem[idx][15:8] = s_data[15:8];
        end
    endtask

    always @(posedge clk) begin
        drive_en <= 1'b0;
        // Second beat of a burst of two goes to the paired column.
        if (wr_second) begin
            store_word(wr_index ^ 1, s_bytesel);
            wr_second <= 1'b0;
        end
        if (rd_delay != 0) begin
            rd_delay <= rd_delay - 1;
            if (rd_delay == 1) begin
                drive_en <= 1'b1;
                dq_out <= mem[rd_index];
                rd_second <= 1'b1;
            end
        end else if (rd_second) begin
            drive_en <= 1'b1;
            dq_out <= mem[rd_index ^ 1];
            rd_second <= 1'b0;
        end
        case (cmd)
            cmd_activate: begin
                open_row[s_banksel] <= s_addr;
            end
            cmd_read: begin
                rd_index <= cmd_index;
                rd_delay <= cas_latency - 1;
            end
            cmd_write: begin
                store_word(cmd_index, s_bytesel);
                wr_index <= cmd_index;
                wr_second <= 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== verification/tb_sdram.sv ====
module tb_sdram;

    import sdram_pkg::*;

    localparam int clk_period = 100;
    localparam int drive_delay = 10;
    localparam int max_lines = 32;
    localparam int num_passes = 5;
    localparam int config_timeout = 2 * (t_reset + t_rp + 2 * t_rc + t_mrd);
    localparam int compl_timeout = 100;

    logic clk;
    logic reset;
    logic cs;
    logic [25:1] h_addr;
    logic [data_width-1:0] h_wdata;
    logic h_wr_en;
    logic [1:0] h_bytesel;
    logic [data_width-1:0] h_rdata;
    logic h_compl;
    logic h_config_done;
    logic s_ras_n;
    logic s_cas_n;
    logic s_wr_en;
    logic [1:0] s_bytesel;
    logic [row_width-1:0] s_addr;
    logic s_cs_n;
    logic s_clken;
    logic [bank_width-1:0] s_banksel;
    wire [data_width-1:0] s_data;

    // Five words per line: op, byte address, write data, byte select, expected.
    logic [31:0] golden [0:5*max_lines-1];
    int num_lines;
    int refresh_seen;

    sdram_top dut_i (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .h_addr(h_addr),
        .h_wdata(h_wdata),
        .h_wr_en(h_wr_en),
        .h_bytesel(h_bytesel),
        .h_rdata(h_rdata),
        .h_compl(h_compl),
        .h_config_done(h_config_done),
        .s_ras_n(s_ras_n),
        .s_cas_n(s_cas_n),
        .s_wr_en(s_wr_en),
        .s_bytesel(s_bytesel),
        .s_addr(s_addr),
        .s_cs_n(s_cs_n),
        .s_clken(s_clken),
        .s_banksel(s_banksel),
        .s_data(s_data)
    );

    sdram_model model_i (
        .clk(clk),
        .s_cs_n(s_cs_n),
        .s_ras_n(s_ras_n),
        .s_cas_n(s_cas_n),
        .s_wr_en(s_wr_en),
        .s_bytesel(s_bytesel),
        .s_addr(s_addr),
        .s_banksel(s_banksel),
        .s_data(s_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // Auto-refresh commands seen on the pins once the device is configured.
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            refresh_seen <= 0;
        end else if (h_config_done &&
                     {s_cs_n, s_ras_n, s_cas_n, s_wr_en} == cmd_refresh) begin
            refresh_seen <= refresh_seen + 1;
        end
    end

    always @(negedge clk) begin
        if (dut_i.ctrl_i.chk_i.fail_count != 0) begin
            $display("A controller assertion failed.");
            $display("RESULT: FAIL");
            $fatal(1, "Stopped on an assertion failure.");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Run aborted.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in %s.", name);
        end
    endtask

    // Also counts completion pulses seen during initialization.
    task automatic wait_config_done(output int compl_count);
        int cycles;
        compl_count = 0;
        cycles = 0;
        while (!h_config_done) begin
            if (cycles == config_timeout) begin
                abort_run("h_config_done did not rise before the timeout.");
            end
            @(posedge clk);
            #drive_delay;
            if (h_compl) begin
                compl_count++;
            end
            cycles++;
        end
    endtask

    // Steps at least one edge so an earlier pulse is not taken again.
    task automatic wait_compl(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #drive_delay;
            cycles++;
            if (cycles > compl_timeout) begin
                abort_run({"No completion in time for ", name, "."});
            end
        end while (!h_compl);
    endtask

    task automatic run_transaction(input int pass_idx, input int line_idx);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] expected;
        string name;
        op = golden[5 * line_idx];
        addr = golden[5 * line_idx + 1];
        expected = golden[5 * line_idx + 4];
        name = $sformatf("pass%0d_line%0d", pass_idx, line_idx);
        cs = 1'b1;
        h_wr_en = op[0];
        h_addr = addr[25:1];
        h_wdata = golden[5 * line_idx + 2][data_width-1:0];
        h_bytesel = golden[5 * line_idx + 3][1:0];
        wait_compl(name);
        check_value({name, "_clken"}, 1, s_clken);
        if (!op[0]) begin
            check_value({name, "_rdata"}, expected, {16'h0000, h_rdata});
        end
    endtask

    initial begin
        int init_compl;
        int gap;
        void'($urandom(12484));
        reset = 1'b1;
        cs = 1'b0;
        h_addr = '0;
        h_wdata = '0;
        h_wr_en = 1'b0;
        h_bytesel = 2'b00;
        for (int i = 0; i < 5 * max_lines; i++) begin
            golden[i] = 32'hffff_ffff;
        end
        $readmemh("verification/sdram_golden.txt", golden);
        num_lines = 0;
        while (num_lines < max_lines && golden[5 * num_lines] != 32'hffff_ffff) begin
            num_lines++;
        end
        if (num_lines == 0) begin
            abort_run("The golden file is missing or holds no transactions.");
        end

        repeat (10) @(posedge clk);
        #drive_delay;
        check_value("reset_config_done", 0, h_config_done);
        check_value("reset_compl", 0, h_compl);
        check_value("reset_cmd", cmd_nop, {s_cs_n, s_ras_n, s_cas_n, s_wr_en});
        reset = 1'b0;

        // Only the mode-set completion may appear before config done.
        wait_config_done(init_compl);
        check_value("init_compl_pulses", 1, init_compl);

        // Repeated passes span several refresh intervals.
        for (int p = 0; p < num_passes; p++) begin
            for (int i = 0; i < num_lines; i++) begin
                gap = $urandom_range(3, 0);
                if (gap != 0) begin
                    cs = 1'b0;
                    repeat (gap) begin
                        @(posedge clk);
                        #drive_delay;
                    end
                end
                run_transaction(p, i);
            end
        end
        cs = 1'b0;
        check_value("refresh_during_run", 1, refresh_seen >= 3);

        if (dut_i.ctrl_i.chk_i.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "Assertion failures recorded.");
        end
    end

endmodule
